//--- hdl/histo_defines.svh
`ifndef HISTO_DEFINES_SVH
`define HISTO_DEFINES_SVH

// raw tdc timestamp width
`define TS_WIDTH 12

// bin address width
`define BIN_BITS 6

// number of histogram bins
`define BIN_NUM 64

// counter width per bin
`define COUNT_WIDTH 8

// width of the rejected hit counter
`define MISS_WIDTH 16

`endif

//--- hdl/histoPkg.sv
`default_nettype none

`include "histo_defines.svh"

package histoPkg;

    // raw hit timestamp from the tdc
    typedef logic [`TS_WIDTH-1:0] timestampT;

    // index of one histogram bin
    typedef logic [`BIN_BITS-1:0] binAddrT;

    // per bin count, unsigned
    // saturates at its maximum instead of wrapping
    typedef logic [`COUNT_WIDTH-1:0] countT;

    // hits that fell outside the window
    typedef logic [`MISS_WIDTH-1:0] missCountT;

endpackage

`default_nettype wire

//--- hdl/tdcBinner.sv
`timescale 1ns/100ps
`default_nettype none

`include "histo_defines.svh"

module tdcBinner (
    input  logic                  clk,
    input  logic                  res,
    // arms hit capture
    input  logic                  acquire,
    // one cycle hit strobe
    input  logic                  hitValid,
    input  histoPkg::timestampT   timestamp,
    // start of the window, held while acquiring
    input  histoPkg::timestampT   winOffset,
    output logic                  binValid,
    output histoPkg::binAddrT     binAddr,
    output histoPkg::missCountT   missCount
);

    // hit accepted for binning at all
    logic                armed;
    // distance from the window start, unsigned
    histoPkg::timestampT delta;
    // delta falls inside the bin range
    logic                inWindow;
    // miss counter already at its limit
    logic                missFull;

    assign armed = hitValid & acquire;

    // wraps for timestamps below the offset
    // so those land far out of range
    assign delta = timestamp - winOffset;

    assign inWindow = (delta < `TS_WIDTH'(`BIN_NUM));

    assign missFull = (missCount == '1);

    // bin strobe, one cycle after the hit
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            binValid <= 1'b0;
        end else begin
            binValid <= armed & inWindow;
        end
    end

    // bin address only loads on a good hit
    always_ff @(posedge clk) begin
        if (armed && inWindow) begin
            // low bits are the bin index
            binAddr <= delta[`BIN_BITS-1:0];
        end
    end

    // out of window hits while armed
    // dropped hits with acquire low are not counted
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            missCount <= '0;
        end else if (armed && !inWindow && !missFull) begin
            missCount <= missCount + 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- hdl/histRam.sv
`timescale 1ns/100ps
`default_nettype none

`include "histo_defines.svh"

module histRam (
    input  logic              clk,
    // write port
    input  logic              wrEn,
    input  histoPkg::binAddrT wrAddr,
    input  histoPkg::countT   wrData,
    // read port, data one cycle after rdEn
    input  logic              rdEn,
    input  histoPkg::binAddrT rdAddr,
    output histoPkg::countT   rdData
);

    // one counter per bin
    // contents undefined until the first clear
    histoPkg::countT mem [`BIN_NUM];

    // write side
    always_ff @(posedge clk) begin
        if (wrEn) begin
            mem[wrAddr] <= wrData;
        end
    end

    // registered read
    // same address as a write in this cycle gives the old word
    always_ff @(posedge clk) begin
        if (rdEn) begin
            rdData <= mem[rdAddr];
        end
    end

endmodule

`default_nettype wire

//--- hdl/histBuilder.sv
`timescale 1ns/100ps
`default_nettype none

`include "histo_defines.svh"

module histBuilder (
    input  logic              clk,
    input  logic              res,
    // bin updates from the binner
    input  logic              binValid,
    input  histoPkg::binAddrT binAddr,
    // clear sweep control
    input  logic              clearStart,
    output logic              clearBusy,
    // host single bin read
    input  logic              hostRdEn,
    input  histoPkg::binAddrT hostRdAddr,
    output histoPkg::countT   hostRdData,
    output logic              hostRdValid,
    // memory write port
    output logic              memWrEn,
    output histoPkg::binAddrT memWrAddr,
    output histoPkg::countT   memWrData,
    // memory read port
    output logic              memRdEn,
    output histoPkg::binAddrT memRdAddr,
    input  histoPkg::countT   memRdData
);

    typedef enum logic {
        Idle,
        Clear
    } stateT;

    stateT             state;
    // next bin the sweep zeroes
    histoPkg::binAddrT clrAddr;

    // accepted requests this cycle
    logic              updAccept;
    logic              hostAccept;

    // stage 1, read in flight
    logic              s1Valid;
    // tag, high for a host read
    logic              s1Host;
    histoPkg::binAddrT s1Addr;

    // stage 2, incremented value waiting for the write
    logic              s2Valid;
    histoPkg::binAddrT s2Addr;
    histoPkg::countT   s2Data;

    // stage 3, copy of the write done at the last edge
    logic              s3Valid;
    histoPkg::binAddrT s3Addr;
    histoPkg::countT   s3Data;

    // bin value after forwarding
    histoPkg::countT   curData;
    // curData plus one, held at the maximum
    histoPkg::countT   incData;

    assign clearBusy = (state == Clear);

    // updates win the read port over the host
    assign updAccept  = binValid & ~clearBusy;
    assign hostAccept = hostRdEn & ~binValid & ~clearBusy;

    // read issued in the cycle the request is taken
    assign memRdEn   = updAccept | hostAccept;
    assign memRdAddr = updAccept ? binAddr : hostRdAddr;

    // sweep owns the write port while clearing
    // in-flight updates get zeroed by the sweep anyway
    assign memWrEn   = clearBusy | s2Valid;
    assign memWrAddr = clearBusy ? clrAddr : s2Addr;
    assign memWrData = clearBusy ? '0 : s2Data;

    // clear FSM
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            state   <= Idle;
            clrAddr <= '0;
        end else begin
            case (state)
                Idle: begin
                    clrAddr <= '0;
                    if (clearStart) begin
                        state <= Clear;
                    end
                end
                Clear: begin
                    clrAddr <= clrAddr + 1'b1;
                    // last bin written on this edge
                    if (clrAddr == `BIN_BITS'(`BIN_NUM - 1)) begin
                        state <= Idle;
                    end
                end
                default: begin
                    state <= Idle;
                end
            endcase
        end
    end

    // forwarding of writes the memory read missed
    // stage 2 is newer so it takes priority
    always_comb begin
        curData = memRdData;
        if (s2Valid && (s2Addr == s1Addr)) begin
            curData = s2Data;
        end else if (s3Valid && (s3Addr == s1Addr)) begin
            curData = s3Data;
        end
    end

    // saturating increment
    assign incData = (curData == '1) ? curData : curData + 1'b1;

    // pipeline valids and tags
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            s1Valid     <= 1'b0;
            s1Host      <= 1'b0;
            s2Valid     <= 1'b0;
            s3Valid     <= 1'b0;
            hostRdValid <= 1'b0;
        end else begin
            s1Valid     <= memRdEn;
            s1Host      <= hostAccept;
            s2Valid     <= s1Valid & ~s1Host;
            s3Valid     <= memWrEn;
            hostRdValid <= s1Valid & s1Host;
        end
    end

    // pipeline addresses and data
    always_ff @(posedge clk) begin
        s1Addr <= memRdAddr;
        s2Addr <= s1Addr;
        s2Data <= incData;
        s3Addr <= memWrAddr;
        s3Data <= memWrData;
        // host gets the plain bin value
        if (s1Valid && s1Host) begin
            hostRdData <= curData;
        end
    end

endmodule

`default_nettype wire

//--- hdl/histoTop.sv
`timescale 1ns/100ps
`default_nettype none

module histoTop (
    input  logic                clk,
    input  logic                res,
    // hit input side
    input  logic                acquire,
    input  logic                hitValid,
    input  histoPkg::timestampT timestamp,
    input  histoPkg::timestampT winOffset,
    // clear control
    input  logic                clearStart,
    output logic                clearBusy,
    // host read side
    input  logic                hostRdEn,
    input  histoPkg::binAddrT   hostRdAddr,
    output histoPkg::countT     hostRdData,
    output logic                hostRdValid,
    // rejected hit count
    output histoPkg::missCountT missCount
);

    // binner to builder
    logic              binValid;
    histoPkg::binAddrT binAddr;

    // builder to memory
    logic              memWrEn;
    histoPkg::binAddrT memWrAddr;
    histoPkg::countT   memWrData;
    logic              memRdEn;
    histoPkg::binAddrT memRdAddr;
    histoPkg::countT   memRdData;

    // window check and bin mapping
    tdcBinner binner (
        .clk       (clk),
        .res       (res),
        .acquire   (acquire),
        .hitValid  (hitValid),
        .timestamp (timestamp),
        .winOffset (winOffset),
        .binValid  (binValid),
        .binAddr   (binAddr),
        .missCount (missCount)
    );

    // bin counters
    histRam ram (
        .clk    (clk),
        .wrEn   (memWrEn),
        .wrAddr (memWrAddr),
        .wrData (memWrData),
        .rdEn   (memRdEn),
        .rdAddr (memRdAddr),
        .rdData (memRdData)
    );

    // read-modify-write engine
    histBuilder builder (
        .clk         (clk),
        .res         (res),
        .binValid    (binValid),
        .binAddr     (binAddr),
        .clearStart  (clearStart),
        .clearBusy   (clearBusy),
        .hostRdEn    (hostRdEn),
        .hostRdAddr  (hostRdAddr),
        .hostRdData  (hostRdData),
        .hostRdValid (hostRdValid),
        .memWrEn     (memWrEn),
        .memWrAddr   (memWrAddr),
        .memWrData   (memWrData),
        .memRdEn     (memRdEn),
        .memRdAddr   (memRdAddr),
        .memRdData   (memRdData)
    );

endmodule

`default_nettype wire

//--- verif/histo_sva.sv
`timescale 1ns/100ps
`default_nettype none

`include "histo_defines.svh"

module histoSva (
    input logic clk,
    input logic res,
    input logic clearBusy,
    input logic binValid,
    input logic hostRdEn,
    input logic hostRdValid,
    input logic memWrEn
);

    // cycles the current sweep has run
    logic [`BIN_BITS:0] busyLen;
    // requests the builder actually takes
    logic               hostTaken;
    logic               updTaken;

    assign hostTaken = hostRdEn & ~binValid & ~clearBusy;
    assign updTaken  = binValid & ~clearBusy;

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            busyLen <= '0;
        end else if (clearBusy) begin
            busyLen <= busyLen + 1'b1;
        end else begin
            busyLen <= '0;
        end
    end

    // sweep never runs past the last bin
    busyBound: assert property (@(posedge clk) disable iff (!res)
        clearBusy |-> (busyLen < `BIN_NUM))
        else $error("clearBusy high for more than the bin count");

    // and never stops early
    busyLength: assert property (@(posedge clk) disable iff (!res)
        $fell(clearBusy) |-> (busyLen == `BIN_NUM))
        else $error("clearBusy length differs from the bin count");

    // host data two cycles after the request
    hostLatency: assert property (@(posedge clk) disable iff (!res)
        hostRdValid == $past(hostTaken, 2))
        else $error("hostRdValid not two cycles after an accepted hostRdEn");

    // write back two cycles after the bin strobe
    updateLatency: assert property (@(posedge clk) disable iff (!res)
        $past(updTaken, 2) |-> memWrEn)
        else $error("memWrEn missing two cycles after an accepted binValid");

endmodule

bind histBuilder histoSva sva (
    .clk         (clk),
    .res         (res),
    .clearBusy   (clearBusy),
    .binValid    (binValid),
    .hostRdEn    (hostRdEn),
    .hostRdValid (hostRdValid),
    .memWrEn     (memWrEn)
);

`default_nettype wire

//--- verif/histoTb.sv
`timescale 1ns/100ps
`default_nettype none

`include "histo_defines.svh"

module histoTb;

    // rough cycle budget of all tests together
    localparam int TestCycles = 3000;

    logic                clk;
    logic                res;
    logic                acquire;
    logic                hitValid;
    histoPkg::timestampT timestamp;
    histoPkg::timestampT winOffset;
    logic                clearStart;
    logic                clearBusy;
    logic                hostRdEn;
    histoPkg::binAddrT   hostRdAddr;
    histoPkg::countT     hostRdData;
    logic                hostRdValid;
    histoPkg::missCountT missCount;

    // expected bins and rejected hit count
    histoPkg::countT     model [`BIN_NUM];
    histoPkg::missCountT missModel;
    // hits waiting to be sent
    histoPkg::timestampT stampQ [$];

    int errors;
    int checks;
    int seedInit;

    histoTop dut (
        .clk         (clk),
        .res         (res),
        .acquire     (acquire),
        .hitValid    (hitValid),
        .timestamp   (timestamp),
        .winOffset   (winOffset),
        .clearStart  (clearStart),
        .clearBusy   (clearBusy),
        .hostRdEn    (hostRdEn),
        .hostRdAddr  (hostRdAddr),
        .hostRdData  (hostRdData),
        .hostRdValid (hostRdValid),
        .missCount   (missCount)
    );

    always #4 clk = ~clk;

    // watchdog
    initial begin
        #(TestCycles * 8 + 2000);
        $display("timeout: tests did not finish within %0d cycles", TestCycles);
        $display(">>> FAIL");
        $finish;
    end

    task automatic checkCount(input string name, input histoPkg::countT expected,
                              input histoPkg::countT actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("FAILED t=%0t %s expected %0d actual %0d", $time, name, expected, actual);
        end
    endtask

    task automatic checkMiss(input string name, input histoPkg::missCountT expected,
                             input histoPkg::missCountT actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("FAILED t=%0t %s expected %0d actual %0d", $time, name, expected, actual);
        end
    endtask

    task automatic checkFlag(input string name, input logic expected, input logic actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("FAILED t=%0t %s expected %b actual %b", $time, name, expected, actual);
        end
    endtask

    // wait n edges and end 1 ns after the last
    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk);
        end
        #1;
    endtask

    // window rule and saturation as the binner and builder apply them
    function automatic void modelHit(input histoPkg::timestampT ts);
        histoPkg::timestampT delta;
        histoPkg::binAddrT   idx;
        delta = ts - winOffset;
        idx   = delta[`BIN_BITS-1:0];
        if (!acquire) begin
            return;
        end
        if (delta < `TS_WIDTH'(`BIN_NUM)) begin
            if (model[idx] != '1) begin
                model[idx] = model[idx] + 1'b1;
            end
        end else if (missModel != '1) begin
            missModel = missModel + 1'b1;
        end
    endfunction

    // drains stampQ with a random idle gap after each hit
    task automatic sendHits(input int minGap, input int maxGap);
        int gap;
        while (stampQ.size() > 0) begin
            hitValid  = 1'b1;
            timestamp = stampQ.pop_front();
            modelHit(timestamp);
            @(posedge clk);
            #1;
            hitValid = 1'b0;
            gap = $urandom_range(maxGap, minGap);
            if (gap > 0) begin
                idle(gap);
            end
        end
    endtask

    task automatic readBin(input histoPkg::binAddrT addr, output histoPkg::countT value);
        int waitCycles;
        hostRdEn   = 1'b1;
        hostRdAddr = addr;
        @(posedge clk);
        #1;
        hostRdEn   = 1'b0;
        waitCycles = 0;
        while (!hostRdValid && waitCycles < 10) begin
            @(posedge clk);
            #1;
            waitCycles++;
        end
        value = hostRdData;
        if (!hostRdValid) begin
            errors++;
            $display("host read of bin %0d returned no data", addr);
        end
    endtask

    task automatic verifyAll();
        histoPkg::countT value;
        for (int i = 0; i < `BIN_NUM; i++) begin
            readBin(`BIN_BITS'(i), value);
            checkCount($sformatf("bin[%0d]", i), model[i], value);
        end
    endtask

    task automatic doClear();
        int busyCycles;
        clearStart = 1'b1;
        @(posedge clk);
        #1;
        clearStart = 1'b0;
        busyCycles = 0;
        while (clearBusy && busyCycles < `BIN_NUM + 8) begin
            @(posedge clk);
            #1;
            busyCycles++;
        end
        if (clearBusy || busyCycles != `BIN_NUM) begin
            errors++;
            $display("clear sweep lasted %0d cycles instead of %0d", busyCycles, `BIN_NUM);
        end
        for (int i = 0; i < `BIN_NUM; i++) begin
            model[i] = '0;
        end
    endtask

    task automatic testResetClear();
        checkFlag("clearBusy", 1'b0, clearBusy);
        checkFlag("hostRdValid", 1'b0, hostRdValid);
        checkMiss("missCount", '0, missCount);
        doClear();
        verifyAll();
    endtask

    task automatic testRandomHits();
        winOffset = `TS_WIDTH'(12'h100);
        idle(1);
        acquire = 1'b1;
        for (int i = 0; i < 40; i++) begin
            stampQ.push_back(winOffset + `TS_WIDTH'($urandom_range(`BIN_NUM - 1, 0)));
        end
        sendHits(1, 3);
        idle(4);
        verifyAll();
        checkMiss("missCount", missModel, missCount);
    endtask

    // back to back hits on one bin then on bins two and three apart
    task automatic testBackToBack();
        for (int i = 0; i < 8; i++) begin
            stampQ.push_back(winOffset + 12'd5);
        end
        for (int i = 0; i < 10; i++) begin
            stampQ.push_back(winOffset + 12'd10 + `TS_WIDTH'(i % 2));
        end
        for (int i = 0; i < 9; i++) begin
            stampQ.push_back(winOffset + 12'd20 + `TS_WIDTH'(i % 3));
        end
        sendHits(0, 0);
        idle(4);
        verifyAll();
    endtask

    task automatic testRejected();
        stampQ.push_back(winOffset - 12'd1);
        stampQ.push_back(winOffset - 12'd50);
        stampQ.push_back(winOffset + 12'd64);
        stampQ.push_back(winOffset + 12'd200);
        stampQ.push_back(winOffset + 12'd4000);
        sendHits(1, 2);
        idle(4);
        checkMiss("missCount", missModel, missCount);
        verifyAll();
        // disarmed hits of both kinds must vanish
        acquire = 1'b0;
        stampQ.push_back(winOffset + 12'd3);
        stampQ.push_back(winOffset - 12'd7);
        stampQ.push_back(winOffset + 12'd3);
        sendHits(0, 1);
        idle(4);
        checkMiss("missCount", missModel, missCount);
        verifyAll();
    endtask

    task automatic testSaturation();
        histoPkg::countT value;
        acquire = 1'b1;
        for (int i = 0; i < 300; i++) begin
            stampQ.push_back(winOffset + 12'd33);
        end
        sendHits(0, 0);
        idle(4);
        readBin(`BIN_BITS'(33), value);
        checkCount("bin[33]", model[33], value);
    endtask

    // stamps that filled bins 0..60 now move up by 8
    task automatic testNewOffset();
        histoPkg::timestampT stamps [16];
        for (int i = 0; i < 16; i++) begin
            stamps[i] = `TS_WIDTH'(12'h100) + `TS_WIDTH'(i * 4);
        end
        // first pass still at the old offset
        for (int i = 0; i < 16; i++) begin
            stampQ.push_back(stamps[i]);
        end
        sendHits(1, 2);
        idle(4);
        verifyAll();
        acquire   = 1'b0;
        winOffset = `TS_WIDTH'(12'h0F8);
        doClear();
        acquire = 1'b1;
        for (int i = 0; i < 16; i++) begin
            stampQ.push_back(stamps[i]);
        end
        sendHits(1, 2);
        idle(4);
        verifyAll();
        checkMiss("missCount", missModel, missCount);
    endtask

    initial begin
        seedInit   = $urandom(89);
        clk        = 1'b0;
        res        = 1'b0;
        acquire    = 1'b0;
        hitValid   = 1'b0;
        timestamp  = '0;
        winOffset  = '0;
        clearStart = 1'b0;
        hostRdEn   = 1'b0;
        hostRdAddr = '0;
        errors     = 0;
        checks     = 0;
        missModel  = '0;
        for (int i = 0; i < `BIN_NUM; i++) begin
            model[i] = '0;
        end
        repeat (3) begin
            @(posedge clk);
        end
        #1;
        res = 1'b1;

        testResetClear();
        testRandomHits();
        testBackToBack();
        testRejected();
        testSaturation();
        testNewOffset();

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- files.f
+incdir+hdl
hdl/histoPkg.sv
hdl/tdcBinner.sv
hdl/histRam.sv
hdl/histBuilder.sv
hdl/histoTop.sv
verif/histo_sva.sv
verif/histoTb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f files.f --top-module histoTb -o VhistoTb

./obj_dir/VhistoTb | tee sim.log

if grep -q -x -F ">>> PASS" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
